/* logic/uart_pkg.sv */
package uart_pkg;

    // Frame format selections
    typedef enum logic {
        DATA_SEVEN = 1'b0,
        DATA_EIGHT = 1'b1
    } data_bits_t;

    typedef enum logic [2:0] {
        PARITY_NONE  = 3'd0,
        PARITY_EVEN  = 3'd1,
        PARITY_ODD   = 3'd2,
        PARITY_MARK  = 3'd3,
        PARITY_SPACE = 3'd4
    } parity_t;

    typedef enum logic {
        STOP_ONE = 1'b0,
        STOP_TWO = 1'b1
    } stop_bits_t;

    // Field order matches the CONFIG register layout, bit 28 down to bit 0
    typedef struct packed {
        stop_bits_t  stop_bits;
        parity_t     parity;
        data_bits_t  data_bits;
        logic [23:0] samples_per_bit;
    } uart_config_t;

    // Receive FIFO entry, frame_err lands in DATA bit 8
    typedef struct packed {
        logic       frame_err;
        logic [7:0] data;
    } rx_entry_t;

    // 16 samples per bit, 8N1
    localparam uart_config_t CONFIG_RESET = '{
        stop_bits:       STOP_ONE,
        parity:          PARITY_NONE,
        data_bits:       DATA_EIGHT,
        samples_per_bit: 24'd16
    };

    // Register word addresses
    localparam logic [1:0] REG_DATA   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_CONFIG = 2'd2;

endpackage

/* logic/uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo #(
    parameter int unsigned FIFO_DEPTH = 8,
    parameter type         payload_t  = logic [7:0]
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     not_empty_o,
    output logic     full_o
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    payload_t         mem_r [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [PTR_W:0]   count_r;
    logic             do_push_w;
    logic             do_pop_w;

    assign full_o      = (count_r == (PTR_W + 1)'(FIFO_DEPTH));
    assign not_empty_o = (count_r != '0);

    // Overflow and underflow requests are dropped
    assign do_push_w = push_i && !full_o;
    assign do_pop_w  = pop_i && not_empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push_w) begin
            mem_r[wr_ptr_r] <= data_i;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_push_w) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_pop_w) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({do_push_w, do_pop_w})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    assign data_o = mem_r[rd_ptr_r];

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::uart_config_t config_i,
    input  logic                   rxd_i,
    output uart_pkg::rx_entry_t    entry_o,
    output logic                   entry_valid_o
);
    import uart_pkg::*;

    logic [2:0]  bits_r;
    logic [23:0] cycles_to_center_r;
    logic        edge_w;
    logic        centre_w;
    logic [11:0] frame_r;
    logic [3:0]  bit_cnt_r;
    logic        done_r;
    logic [3:0]  frame_len_w;
    logic [11:0] aligned_w;
    logic [3:0]  parity_idx_w;
    logic [3:0]  stop_idx_w;
    logic        data_xor_w;
    logic        parity_good_w;
    logic        stop_good_w;
    logic        start_good_w;
    logic [7:0]  data_w;
    rx_entry_t   entry_r;
    logic        entry_valid_r;

    // Oldest sample sits in bit 0
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bits_r <= 3'b111;
        end else begin
            bits_r <= {rxd_i, bits_r[2:1]};
        end
    end

    assign edge_w   = (bits_r[0] != bits_r[1]);
    assign centre_w = (cycles_to_center_r == 24'd0) && !edge_w;

    // Re-centre on every edge, otherwise one full bit period between centres
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cycles_to_center_r <= '0;
        end else if (edge_w) begin
            cycles_to_center_r <= {1'b0, config_i.samples_per_bit[23:1]};
        end else if (cycles_to_center_r == 24'd0) begin
            cycles_to_center_r <= config_i.samples_per_bit - 24'd1;
        end else begin
            cycles_to_center_r <= cycles_to_center_r - 24'd1;
        end
    end

    // start + data + parity + stop
    assign frame_len_w = 4'd9 + {3'b0, config_i.data_bits == DATA_EIGHT}
                       + {3'b0, config_i.parity != PARITY_NONE}
                       + {3'b0, config_i.stop_bits == STOP_TWO};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            frame_r   <= '1;
            bit_cnt_r <= '0;
            done_r    <= 1'b0;
        end else begin
            done_r <= centre_w && (bit_cnt_r == 4'd1);
            if (done_r) begin
                frame_r <= '1;
            end
            if (centre_w) begin
                if (bit_cnt_r != 4'd0) begin
                    frame_r   <= {bits_r[0], frame_r[11:1]};
                    bit_cnt_r <= bit_cnt_r - 4'd1;
                end else if (!bits_r[0]) begin
                    // Start bit found while idle
                    frame_r   <= {bits_r[0], frame_r[11:1]};
                    bit_cnt_r <= frame_len_w - 4'd1;
                end
            end
        end
    end

    // Frame was shifted in from the top, bring the start bit down to bit 0
    assign aligned_w    = frame_r >> (4'd12 - frame_len_w);
    assign parity_idx_w = (config_i.data_bits == DATA_EIGHT) ? 4'd9 : 4'd8;
    assign stop_idx_w   = parity_idx_w + {3'b0, config_i.parity != PARITY_NONE};
    assign start_good_w = !aligned_w[0];

    always_comb begin
        if (config_i.data_bits == DATA_EIGHT) begin
            data_w = aligned_w[8:1];
        end else begin
            data_w = {1'b0, aligned_w[7:1]};
        end
        data_xor_w = ^data_w;

        case (config_i.parity)
            PARITY_EVEN:  parity_good_w = (aligned_w[parity_idx_w] == data_xor_w);
            PARITY_ODD:   parity_good_w = (aligned_w[parity_idx_w] != data_xor_w);
            PARITY_MARK:  parity_good_w = aligned_w[parity_idx_w];
            PARITY_SPACE: parity_good_w = !aligned_w[parity_idx_w];
            default:      parity_good_w = 1'b1;
        endcase

        stop_good_w = aligned_w[stop_idx_w];
        if (config_i.stop_bits == STOP_TWO) begin
            stop_good_w = stop_good_w && aligned_w[stop_idx_w + 4'd1];
        end
    end

    // Every finished frame is reported, good or bad
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            entry_r       <= '0;
            entry_valid_r <= 1'b0;
        end else begin
            entry_valid_r <= done_r;
            if (done_r) begin
                entry_r.data      <= data_w;
                entry_r.frame_err <= !(start_good_w && parity_good_w && stop_good_w);
            end
        end
    end

    assign entry_o       = entry_r;
    assign entry_valid_o = entry_valid_r;

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_pkg::uart_config_t config_i,
    input  logic [7:0]             data_i,
    input  logic                   valid_i,
    output logic                   take_o,
    output logic                   busy_o,
    output logic                   txd_o
);
    import uart_pkg::*;

    logic        take_r;
    logic        busy_r;
    logic [11:0] shift_r;
    logic [3:0]  bits_left_r;
    logic [23:0] period_cnt_r;
    logic [23:0] spb_r;
    logic [11:0] frame_w;
    logic [3:0]  frame_len_w;
    logic [3:0]  parity_idx_w;
    logic        data_xor_w;
    logic        parity_bit_w;

    assign frame_len_w = 4'd9 + {3'b0, config_i.data_bits == DATA_EIGHT}
                       + {3'b0, config_i.parity != PARITY_NONE}
                       + {3'b0, config_i.stop_bits == STOP_TWO};

    assign parity_idx_w = (config_i.data_bits == DATA_EIGHT) ? 4'd9 : 4'd8;

    // Same parity rules as the receiver
    always_comb begin
        if (config_i.data_bits == DATA_EIGHT) begin
            data_xor_w = ^data_i;
        end else begin
            data_xor_w = ^data_i[6:0];
        end

        case (config_i.parity)
            PARITY_EVEN:  parity_bit_w = data_xor_w;
            PARITY_ODD:   parity_bit_w = !data_xor_w;
            PARITY_SPACE: parity_bit_w = 1'b0;
            default:      parity_bit_w = 1'b1;
        endcase
    end

    // LSB first, the ones above the parity bit serve as stop bits
    always_comb begin
        frame_w    = '1;
        frame_w[0] = 1'b0;
        if (config_i.data_bits == DATA_EIGHT) begin
            frame_w[8:1] = data_i;
        end else begin
            frame_w[7:1] = data_i[6:0];
        end
        if (config_i.parity != PARITY_NONE) begin
            frame_w[parity_idx_w] = parity_bit_w;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            take_r       <= 1'b0;
            busy_r       <= 1'b0;
            shift_r      <= '1;
            bits_left_r  <= '0;
            period_cnt_r <= '0;
            spb_r        <= '0;
        end else begin
            take_r <= 1'b0;
            if (take_r) begin
                // Config is captured here and held for the whole frame
                shift_r      <= frame_w;
                bits_left_r  <= frame_len_w;
                spb_r        <= config_i.samples_per_bit;
                period_cnt_r <= config_i.samples_per_bit - 24'd1;
                busy_r       <= 1'b1;
            end else if (busy_r) begin
                if (period_cnt_r == 24'd0) begin
                    period_cnt_r <= spb_r - 24'd1;
                    if (bits_left_r == 4'd1) begin
                        busy_r <= 1'b0;
                    end else begin
                        shift_r     <= {1'b1, shift_r[11:1]};
                        bits_left_r <= bits_left_r - 4'd1;
                    end
                end else begin
                    period_cnt_r <= period_cnt_r - 24'd1;
                end
            end else if (valid_i) begin
                take_r <= 1'b1;
            end
        end
    end

    assign take_o = take_r;
    assign busy_o = busy_r || take_r;
    // Line rests on the last stop bit, which is high
    assign txd_o  = shift_r[0];

endmodule

/* logic/uart_wb_regs.sv */
`timescale 1ns/1ps

module uart_wb_regs (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [1:0]             wb_adr_i,
    input  logic [31:0]            wb_dat_i,
    output logic [31:0]            wb_dat_o,
    output logic                   wb_ack_o,
    output uart_pkg::uart_config_t config_o,
    input  uart_pkg::rx_entry_t    rx_entry_i,
    input  logic                   rx_not_empty_i,
    input  logic                   tx_full_i,
    input  logic                   tx_busy_i,
    input  logic                   tx_not_empty_i,
    output logic                   tx_push_o,
    output logic [7:0]             tx_data_o,
    output logic                   rx_pop_o
);
    import uart_pkg::*;

    logic         ack_r;
    uart_config_t config_r;
    logic         rd_w;
    logic         wr_w;
    logic [2:0]   status_w;
    logic [31:0]  rd_data_w;

    // Single-cycle ack, the !ack_r term keeps it from repeating
    // while the master still holds stb in the ack cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= wb_cyc_i && wb_stb_i && !ack_r;
        end
    end

    // Master holds we and adr until it sees ack
    assign rd_w = ack_r && !wb_we_i;
    assign wr_w = ack_r && wb_we_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            config_r <= CONFIG_RESET;
        end else if (wr_w && (wb_adr_i == REG_CONFIG)) begin
            config_r <= uart_config_t'(wb_dat_i[28:0]);
        end
    end

    // rx ready, tx full, tx drained
    assign status_w = {
        !tx_busy_i && !tx_not_empty_i,
        tx_full_i,
        rx_not_empty_i
    };

    always_comb begin
        rd_data_w = '0;
        if (rd_w) begin
            case (wb_adr_i)
                REG_DATA: begin
                    if (rx_not_empty_i) begin
                        rd_data_w = {23'b0, rx_entry_i};
                    end
                end
                REG_STATUS: rd_data_w = {29'b0, status_w};
                REG_CONFIG: rd_data_w = {3'b0, config_r};
                default:    rd_data_w = '0;
            endcase
        end
    end

    // FIFO strobes only in the ack cycle of a DATA access
    assign tx_push_o = wr_w && (wb_adr_i == REG_DATA) && !tx_full_i;
    assign tx_data_o = wb_dat_i[7:0];
    assign rx_pop_o  = rd_w && (wb_adr_i == REG_DATA) && rx_not_empty_i;

    assign wb_dat_o = rd_data_w;
    assign wb_ack_o = ack_r;
    assign config_o = config_r;

endmodule

/* logic/uart_top.sv */
`timescale 1ns/1ps

module uart_top #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [1:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    input  logic        rxd_i,
    output logic        txd_o
);
    import uart_pkg::*;

    uart_config_t config_w;

    // Receive side
    rx_entry_t rx_entry_w;
    logic      rx_entry_valid_w;
    rx_entry_t rx_head_w;
    logic      rx_not_empty_w;
    logic      rx_pop_w;

    // Transmit side
    logic [7:0] tx_push_data_w;
    logic       tx_push_w;
    logic [7:0] tx_head_w;
    logic       tx_not_empty_w;
    logic       tx_full_w;
    logic       tx_take_w;
    logic       tx_busy_w;

    uart_wb_regs regs_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .config_o       (config_w),
        .rx_entry_i     (rx_head_w),
        .rx_not_empty_i (rx_not_empty_w),
        .tx_full_i      (tx_full_w),
        .tx_busy_i      (tx_busy_w),
        .tx_not_empty_i (tx_not_empty_w),
        .tx_push_o      (tx_push_w),
        .tx_data_o      (tx_push_data_w),
        .rx_pop_o       (rx_pop_w)
    );

    uart_rx rx_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .config_i      (config_w),
        .rxd_i         (rxd_i),
        .entry_o       (rx_entry_w),
        .entry_valid_o (rx_entry_valid_w)
    );

    // No ready toward the receiver, entries arriving while full are lost
    uart_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (rx_entry_t)
    ) rx_fifo_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (rx_entry_valid_w),
        .data_i      (rx_entry_w),
        .pop_i       (rx_pop_w),
        .data_o      (rx_head_w),
        .not_empty_o (rx_not_empty_w),
        .full_o      ()
    );

    uart_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (logic [7:0])
    ) tx_fifo_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (tx_push_w),
        .data_i      (tx_push_data_w),
        .pop_i       (tx_take_w),
        .data_o      (tx_head_w),
        .not_empty_o (tx_not_empty_w),
        .full_o      (tx_full_w)
    );

    uart_tx tx_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .config_i (config_w),
        .data_i   (tx_head_w),
        .valid_i  (tx_not_empty_w),
        .take_o   (tx_take_w),
        .busy_o   (tx_busy_w),
        .txd_o    (txd_o)
    );

endmodule

/* tests/uart_properties.sv */
`timescale 1ns/1ps

module uart_properties (
    input logic clk_i,
    input logic rst_n_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic push_i,
    input logic pop_i,
    input logic not_empty_i,
    input logic full_i
);

    // Single-cycle ack per bus cycle
    ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else $error("wb_ack_o held high for two cycles");

    // Ack is only ever an answer to a strobe
    ack_after_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |-> $past(cyc_i && stb_i))
        else $error("wb_ack_o raised without a preceding strobe");

    // Full is only reached through a push
    fifo_full_on_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(full_i) |-> $past(push_i))
        else $error("FIFO became full without a push");

    // Emptying takes a pop
    fifo_empty_on_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(not_empty_i) |-> $past(pop_i))
        else $error("FIFO became empty without a pop");

endmodule

/* tests/uart_tb.sv */
`timescale 1ns/1ps

module uart_tb;

    localparam int unsigned FIFO_DEPTH = 4;
    localparam logic [1:0]  REG_DATA   = 2'd0;
    localparam logic [1:0]  REG_STATUS = 2'd1;
    localparam logic [1:0]  REG_CONFIG = 2'd2;
    // 16 samples per bit, eight data bits, no parity, one stop bit
    localparam logic [31:0] CONFIG_AT_RESET = 32'h0100_0010;

    logic        clk_i;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [1:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        rxd_i;
    logic        txd_o;

    integer seed;
    int     errors;
    int     checks;
    int     cycle_cnt;
    int     cycle_limit;

    // Test steps as read from the data file
    logic [7:0]  op_q[$];
    logic [31:0] cfg_q[$];
    logic [7:0]  byte_q[$];
    int          flag_q[$];
    logic [7:0]  exp_byte_q[$];
    int          exp_err_q[$];

    uart_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .rxd_i    (rxd_i),
        .txd_o    (txd_o)
    );

    bind uart_wb_regs uart_properties bus_props_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cyc_i       (wb_cyc_i),
        .stb_i       (wb_stb_i),
        .ack_i       (wb_ack_o),
        .push_i      (1'b0),
        .pop_i       (1'b0),
        .not_empty_i (1'b0),
        .full_i      (1'b0)
    );

    bind uart_fifo uart_properties fifo_props_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cyc_i       (1'b0),
        .stb_i       (1'b0),
        .ack_i       (1'b0),
        .push_i      (push_i),
        .pop_i       (pop_i),
        .not_empty_i (not_empty_o),
        .full_i      (full_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = !clk_i;
    end

    // Run limit, set from the test lengths once the file is read
    initial begin
        cycle_cnt = 0;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int data_bits(input logic [31:0] cfg);
        return cfg[24] ? 8 : 7;
    endfunction

    function automatic logic [7:0] data_mask(input logic [31:0] cfg);
        return cfg[24] ? 8'hFF : 8'h7F;
    endfunction

    function automatic int frame_length(input logic [31:0] cfg);
        return 1 + data_bits(cfg) + ((cfg[27:25] != 3'd0) ? 1 : 0) + (cfg[28] ? 2 : 1);
    endfunction

    // Serial frame, LSB first from bit 0, unused bits high
    function automatic logic [11:0] build_frame(input logic [31:0] cfg, input logic [7:0] data);
        logic [11:0] f;
        logic [7:0]  d;
        logic        ones;
        int          pos;
        d = data & data_mask(cfg);
        ones = ^d;
        f = '1;
        f[0] = 1'b0;
        pos = 1;
        for (int i = 0; i < data_bits(cfg); i++) begin
            f[pos] = d[i];
            pos++;
        end
        case (cfg[27:25])
            3'd1:    f[pos] = ones;
            3'd2:    f[pos] = !ones;
            3'd3:    f[pos] = 1'b1;
            3'd4:    f[pos] = 1'b0;
            default: f[pos] = 1'b1;
        endcase
        return f;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdata;
        do @(negedge clk_i); while (wb_ack_o !== 1'b1);
        rdata = wb_dat_o;
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] adr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdata, unused);
    endtask

    task automatic bus_read(input logic [1:0] adr, output logic [31:0] rdata);
        bus_cycle(1'b0, adr, 32'h0, rdata);
    endtask

    // Polls STATUS until the bit takes the value or the cycle budget runs out
    task automatic wait_status(input int bit_idx, input logic value, input int max_cycles);
        logic [31:0] st;
        int          start;
        start = cycle_cnt;
        bus_read(REG_STATUS, st);
        while (st[bit_idx] !== value && (cycle_cnt - start) < max_cycles) begin
            bus_read(REG_STATUS, st);
        end
        assert (st[bit_idx] === value) else begin
            errors++;
            $display("STATUS bit %0d did not become %0d within %0d cycles",
                     bit_idx, value, max_cycles);
        end
    endtask

    // corrupt: 1 flips the parity bit, 2 pulls the first stop bit low
    task automatic send_frame(input logic [31:0] cfg, input logic [7:0] data, input int corrupt);
        logic [11:0] f;
        int          len;
        int          spb;
        int          gap;
        f = build_frame(cfg, data);
        len = frame_length(cfg);
        spb = int'(cfg[23:0]);
        if (corrupt == 1) begin
            f[data_bits(cfg) + 1] = !f[data_bits(cfg) + 1];
        end else if (corrupt == 2) begin
            f[len - (cfg[28] ? 2 : 1)] = 1'b0;
        end
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(posedge clk_i);
        for (int b = 0; b < len; b++) begin
            @(posedge clk_i);
            rxd_i <= f[b];
            repeat (spb - 1) @(posedge clk_i);
        end
        @(posedge clk_i);
        rxd_i <= 1'b1;
    endtask

    // Samples txd_o at bit centres counted from the start edge
    task automatic watch_tx(input logic [31:0] cfg, output logic [11:0] bits);
        int spb;
        spb = int'(cfg[23:0]);
        bits = '1;
        do @(negedge clk_i); while (txd_o !== 1'b0);
        repeat (spb / 2) @(negedge clk_i);
        bits[0] = txd_o;
        for (int b = 1; b < frame_length(cfg); b++) begin
            repeat (spb) @(negedge clk_i);
            bits[b] = txd_o;
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] cfg;
        logic [7:0]  data;
        int          flag;
        logic [7:0]  exp_b;
        int          exp_e;
        fd = $fopen("tests/uart_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open tests/uart_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %d %h %d", op, cfg, data, flag, exp_b, exp_e);
                if (n == 6) begin
                    op_q.push_back(op);
                    cfg_q.push_back(cfg);
                    byte_q.push_back(data);
                    flag_q.push_back(flag);
                    exp_byte_q.push_back(exp_b);
                    exp_err_q.push_back(exp_e);
                end else begin
                    errors++;
                    $display("Malformed line in test file: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_step(input int i);
        logic [31:0] cfg;
        logic [31:0] rd;
        logic [11:0] bits;
        int          frame_cycles;
        cfg = cfg_q[i];
        frame_cycles = frame_length(cfg) * int'(cfg[23:0]);
        bus_write(REG_CONFIG, cfg);
        case (op_q[i])
            "C": begin
                bus_read(REG_CONFIG, rd);
                check_value("wb_dat_o (CONFIG)", rd, cfg & 32'h1FFF_FFFF);
                bus_read(REG_STATUS, rd);
                check_value("wb_dat_o (STATUS tx idle)", rd & 32'h4, 32'h4);
            end
            "R": begin
                send_frame(cfg, byte_q[i], flag_q[i]);
                wait_status(0, 1'b1, frame_cycles + 100);
                bus_read(REG_DATA, rd);
                check_value("wb_dat_o (DATA)", rd,
                            {23'b0, exp_err_q[i] != 0, exp_byte_q[i]});
            end
            "T": begin
                bus_write(REG_DATA, {24'b0, byte_q[i]});
                watch_tx(cfg, bits);
                check_value("txd_o frame", {20'b0, bits}, {20'b0, build_frame(cfg, byte_q[i])});
                check_value("txd_o data", {24'b0, bits[8:1] & data_mask(cfg)},
                            {24'b0, exp_byte_q[i]});
                wait_status(2, 1'b1, 2 * frame_cycles + 100);
            end
            "V": begin
                if (flag_q[i] == 0) begin
                    for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
                        send_frame(cfg, 8'(byte_q[i] + k), 0);
                    end
                    for (int k = 0; k < FIFO_DEPTH; k++) begin
                        bus_read(REG_DATA, rd);
                        check_value("wb_dat_o (DATA overflow)", rd,
                                    {24'b0, 8'(exp_byte_q[i] + k) & data_mask(cfg)});
                    end
                    bus_read(REG_STATUS, rd);
                    check_value("wb_dat_o (STATUS rx not empty)", rd & 32'h1, 32'h0);
                end else begin
                    for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
                        bus_write(REG_DATA, {24'b0, 8'(byte_q[i] + k)});
                    end
                    bus_read(REG_STATUS, rd);
                    check_value("wb_dat_o (STATUS tx full)", {31'b0, rd[1]}, exp_err_q[i]);
                    wait_status(2, 1'b1, (FIFO_DEPTH + 3) * frame_cycles + 100);
                end
            end
            default: begin
                errors++;
                $display("Unknown opcode %c in test step %0d", op_q[i], i);
            end
        endcase
    endtask

    initial begin
        logic [31:0] rd;
        longint      total;
        seed        = 32'h7f52c842;
        errors      = 0;
        checks      = 0;
        cycle_limit = 32'h7FFF_FFFF;
        rst_n_i  <= 1'b0;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        wb_adr_i <= 2'd0;
        wb_dat_i <= 32'h0;
        rxd_i    <= 1'b1;

        load_tests();
        if (op_q.size() == 0) begin
            errors++;
            $display("No test steps were loaded");
        end

        // Frame time of every step plus bus traffic headroom
        total = 0;
        foreach (op_q[i]) begin
            total += frame_length(cfg_q[i]) * int'(cfg_q[i][23:0])
                   * ((op_q[i] == "V") ? (FIFO_DEPTH + 2) : 1);
        end
        cycle_limit = int'(total + total / 4 + 200 * op_q.size() + 1000);

        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        bus_read(REG_CONFIG, rd);
        check_value("wb_dat_o (CONFIG after reset)", rd, CONFIG_AT_RESET);

        foreach (op_q[i]) begin
            run_step(i);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tests/uart_tests.txt */
# op cfg byte flag exp_byte exp_err  (op C config, R receive, T transmit, V overflow)
# flag for R is 1 flipped parity, 2 low stop bit; for V it is 0 receive, 1 transmit
C 1500000C 00 0 00 0
C 01000010 00 0 00 0
R 01000010 A5 0 A5 0
R 03000010 3C 0 3C 0
R 1500000C 81 0 81 0
R 06000014 D7 0 57 0
R 1800000A 7F 0 7F 0
R 1100000E 00 0 00 0
R 00000010 FF 0 7F 0
R 0200000B 4B 0 4B 0
R 0500000D 96 0 96 0
R 17000010 E1 0 E1 0
R 0900000A 5A 0 5A 0
R 03000010 55 1 55 1
R 03000010 55 0 55 0
R 01000010 C3 2 C3 1
R 01000010 3C 0 3C 0
R 1500000C 0F 2 0F 1
R 1500000C F0 0 F0 0
T 01000010 A5 0 A5 0
T 03000010 6E 0 6E 0
T 1500000C 81 0 81 0
T 06000014 D7 0 57 0
T 1800000A 33 0 33 0
T 0200000B 4B 0 4B 0
V 01000010 10 0 10 0
V 01000010 20 1 00 1

/* uart_core.f */
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_wb_regs.sv
logic/uart_top.sv
tests/uart_properties.sv
tests/uart_tb.sv

/* Bender.yml */
package:
  name: uart_core

sources:
  - logic/uart_pkg.sv
  - logic/uart_fifo.sv
  - logic/uart_rx.sv
  - logic/uart_tx.sv
  - logic/uart_wb_regs.sv
  - logic/uart_top.sv
  - target: test
    files:
      - tests/uart_properties.sv
      - tests/uart_tb.sv
